// File: verif/exec_stim.txt
# name instr rs1 rs2 pc expected, all values in hex
# a line holding only gap keeps in_valid low for one cycle
add_ovf     002081b3 7fffffff 00000001 00001000 80000000
sub_neg     402081b3 00000003 00000005 00001000 fffffffe
sll_mask    002091b3 00000001 00000024 00001000 00000010
slt_mixed   0020a1b3 ffffffff 00000001 00001000 00000001
sltu_mixed  0020b1b3 ffffffff 00000001 00001000 00000000
xor         0020c1b3 f0f0f0f0 ff00ff00 00001000 0ff00ff0
srl_neg     0020d1b3 f0000000 00000004 00001000 0f000000
sra_neg     4020d1b3 f0000000 00000004 00001000 ff000000
or          0020e1b3 0000f0f0 00ff0000 00001000 00fff0f0
and         0020f1b3 12345678 0f0f0f0f 00001000 02040608
addi_neg    ffb08193 00000064 11111111 00001000 0000005f
slti        fff0a193 00000005 11111111 00001000 00000000
sltiu       fff0b193 00000005 11111111 00001000 00000001
xori        0f00c193 12345678 11111111 00001000 12345688
ori_sext    8000e193 00000123 11111111 00001000 fffff923
andi        7ff0f193 deadbeef 11111111 00001000 000006ef
slli        00409193 000000ff 11111111 00001000 00000ff0
srli        0080d193 80000000 11111111 00001000 00800000
srai        4080d193 80000000 11111111 00001000 ff800000
gap
mul_neg     022081b3 fffffffd 00000007 00001000 ffffffeb
mulh_min    022091b3 80000000 80000000 00001000 40000000
mulh_neg    022091b3 12345678 ffffffff 00001000 ffffffff
div_neg     0220c1b3 ffffffec 00000006 00001000 fffffffd
divu        0220d1b3 ffffffec 00000006 00001000 2aaaaaa7
rem_neg     0220e1b3 ffffffec 00000006 00001000 fffffffe
remu        0220f1b3 ffffffec 00000006 00001000 00000002
div_zero    0220c1b3 00001234 00000000 00001000 ffffffff
divu_zero   0220d1b3 00001234 00000000 00001000 ffffffff
rem_zero    0220e1b3 00001234 00000000 00001000 00001234
remu_zero   0220f1b3 00001234 00000000 00001000 00001234
div_ovf     0220c1b3 80000000 ffffffff 00001000 80000000
rem_ovf     0220e1b3 80000000 ffffffff 00001000 00000000
lui         123451b7 aaaaaaaa bbbbbbbb 00001000 12345000
auipc       fffff197 aaaaaaaa bbbbbbbb 00002000 00001000
jal         008000ef aaaaaaaa bbbbbbbb 00000100 00000104
jalr_wrap   000280e7 00005555 bbbbbbbb fffffffc 00000000

// File: compile.f
+incdir+src
src/riscv_isa_pkg.sv
src/pipe_pkg.sv
src/alu_ctrl.sv
src/instr_decode.sv
src/id_ex_stage.sv
src/exec_alu.sv
src/exec_slice_top.sv
verif/exec_slice_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = exec_slice_tb
FILELIST = compile.f

BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)

// File: verif/exec_slice_tb.sv
`default_nettype none
`timescale 1ns/1ps

module exec_slice_tb;

        localparam int RESET_CYCLES = 8;
        localparam int MAX_VECTORS  = 64;
        localparam int DRAIN_CYCLES = 10;

        logic                   clk;
        logic                   reset;
        logic                   in_valid;
        riscv_isa_pkg::word_t   instr;
        riscv_isa_pkg::word_t   rs1_val;
        riscv_isa_pkg::word_t   rs2_val;
        riscv_isa_pkg::word_t   pc;
        logic                   out_valid;
        riscv_isa_pkg::word_t   result;

        // ******************************
        // Vectors and scoreboard
        // ******************************

        string                  vec_name [MAX_VECTORS];
        riscv_isa_pkg::word_t   vec_instr [MAX_VECTORS];
        riscv_isa_pkg::word_t   vec_rs1 [MAX_VECTORS];
        riscv_isa_pkg::word_t   vec_rs2 [MAX_VECTORS];
        riscv_isa_pkg::word_t   vec_pc [MAX_VECTORS];
        riscv_isa_pkg::word_t   vec_exp [MAX_VECTORS];
        logic                   vec_gap [MAX_VECTORS];
        int                     vec_count = 0;

        string                  name_q [$];
        riscv_isa_pkg::word_t   expect_q [$];
        int                     due_q [$]; // Cycle at which each result must show

        int                     cycle = 0;
        int                     cycle_limit = 0;
        int                     pass_count = 0;
        int                     fail_count = 0;
        logic                   run_done = 1'b0;

        exec_slice_top dut_i (
                .clk       (clk),
                .reset     (reset),
                .in_valid  (in_valid),
                .instr     (instr),
                .rs1_val   (rs1_val),
                .rs2_val   (rs2_val),
                .pc        (pc),
                .out_valid (out_valid),
                .result    (result)
        );

        initial
        begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        always @(posedge clk)
                cycle <= cycle + 1;

        task automatic load_vectors();
                int                     fd;
                int                     fields;
                string                  line;
                string                  nm;
                riscv_isa_pkg::word_t   f_instr;
                riscv_isa_pkg::word_t   f_rs1;
                riscv_isa_pkg::word_t   f_rs2;
                riscv_isa_pkg::word_t   f_pc;
                riscv_isa_pkg::word_t   f_exp;

                fd = $fopen("verif/exec_stim.txt", "r");
                if (fd == 0)
                begin
                        $display("cannot open the stimulus file verif/exec_stim.txt");
                        fail_count++;
                end
                else
                begin
                        while ($fgets(line, fd) != 0 && vec_count < MAX_VECTORS)
                        begin
                                fields = $sscanf(line, "%s %h %h %h %h %h", nm,
                                                 f_instr, f_rs1, f_rs2, f_pc, f_exp);
                                if (fields <= 0 || nm.getc(0) == "#")
                                        continue; // Blank or comment
                                vec_name[vec_count] = nm;
                                vec_gap[vec_count]  = (nm == "gap");
                                if (!vec_gap[vec_count] && fields != 6)
                                begin
                                        $display("stimulus line could not be read: %s", line);
                                        fail_count++;
                                        continue;
                                end
                                vec_instr[vec_count] = f_instr;
                                vec_rs1[vec_count]   = f_rs1;
                                vec_rs2[vec_count]   = f_rs2;
                                vec_pc[vec_count]    = f_pc;
                                vec_exp[vec_count]   = f_exp;
                                vec_count++;
                        end
                        $fclose(fd);
                end
        endtask

        // Back to back, one item per cycle
        task automatic drive_vectors();
                int i;

                for (i = 0; i < vec_count; i++)
                begin
                        @(posedge clk);
                        #1;
                        in_valid = !vec_gap[i];
                        if (!vec_gap[i])
                        begin
                                instr   = vec_instr[i];
                                rs1_val = vec_rs1[i];
                                rs2_val = vec_rs2[i];
                                pc      = vec_pc[i];
                                name_q.push_back(vec_name[i]);
                                expect_q.push_back(vec_exp[i]);
                                due_q.push_back(cycle + 2);
                        end
                end
                @(posedge clk);
                #1;
                in_valid = 1'b0;
        endtask

        task automatic wait_for_drain();
                int waited;

                waited = 0;
                while (name_q.size() > 0 && waited < DRAIN_CYCLES)
                begin
                        @(negedge clk);
                        waited++;
                end
                repeat (3) @(negedge clk); // out_valid must stay low
        endtask

        task automatic check_result();
                string                  nm;
                riscv_isa_pkg::word_t   exp;
                int                     due;

                if (name_q.size() == 0)
                begin
                        $display("out_valid high at cycle %0d with no result expected", cycle);
                        fail_count++;
                end
                else
                begin
                        nm  = name_q.pop_front();
                        exp = expect_q.pop_front();
                        due = due_q.pop_front();
                        if (due != cycle)
                        begin
                                $display("%s: result came at cycle %0d, due at cycle %0d",
                                         nm, cycle, due);
                                fail_count++;
                        end
                        else if (result !== exp)
                        begin
                                $display("mismatch %s: expected %h, actual %h", nm, exp, result);
                                fail_count++;
                        end
                        else
                        begin
                                $display("pass %s: %h", nm, result);
                                pass_count++;
                        end
                end
        endtask

        // ******************************
        // Monitor and timeout
        // ******************************

        always @(negedge clk)
        begin
                if (out_valid === 1'b1)
                        check_result();
                else if (due_q.size() > 0 && due_q[0] <= cycle)
                begin
                        $display("%s: no result at cycle %0d, out_valid stayed low",
                                 name_q.pop_front(), cycle);
                        void'(expect_q.pop_front());
                        void'(due_q.pop_front());
                        fail_count++;
                end
        end

        always @(posedge clk)
        begin
                if (!run_done && cycle_limit > 0 && cycle >= cycle_limit)
                begin
                        $display("timeout: run still busy after %0d cycles", cycle);
                        $display("CHECKS FAILED");
                        $finish;
                end
        end

        initial
        begin
                reset    = 1'b1;
                in_valid = 1'b1; // Strobe during reset must not reach out_valid
                instr    = '0;
                rs1_val  = '0;
                rs2_val  = '0;
                pc       = '0;

                load_vectors();
                cycle_limit = RESET_CYCLES + vec_count + 20;

                repeat (RESET_CYCLES) @(posedge clk);
                #1;
                reset    = 1'b0;
                in_valid = 1'b0;

                drive_vectors();
                wait_for_drain();
                run_done = 1'b1;

                if (name_q.size() > 0)
                begin
                        $display("%0d expected results never arrived", name_q.size());
                        fail_count += name_q.size();
                end

                $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
                if (fail_count == 0)
                        $display("ALL CHECKS PASSED");
                else
                        $display("CHECKS FAILED");
                $finish;
        end

endmodule

`default_nettype wire

// File: src/exec_slice_top.sv
`default_nettype none
`timescale 1ns/1ps

module exec_slice_top (
        input  wire logic                   clk,
        input  wire logic                   reset,
        input  wire logic                   in_valid,
        input  wire riscv_isa_pkg::word_t   instr,
        input  wire riscv_isa_pkg::word_t   rs1_val,
        input  wire riscv_isa_pkg::word_t   rs2_val,
        input  wire riscv_isa_pkg::word_t   pc,
        output logic                        out_valid,
        output riscv_isa_pkg::word_t        result
);

        pipe_pkg::decoded_instr_t   dec;
        pipe_pkg::issue_t           issue;
        pipe_pkg::exec_result_t     res;

        // ******************************
        // Decode, issue, execute
        // ******************************

        instr_decode instr_decode_i (
                .in_valid (in_valid),
                .instr    (instr),
                .rs1_val  (rs1_val),
                .rs2_val  (rs2_val),
                .pc       (pc),
                .dec      (dec)
        );

        id_ex_stage id_ex_stage_i (
                .clk   (clk),
                .reset (reset),
                .dec   (dec),
                .issue (issue)
        );

        exec_alu exec_alu_i (
                .clk   (clk),
                .reset (reset),
                .issue (issue),
                .res   (res)
        );

        assign out_valid = res.valid; // Two cycles after in_valid
        assign result    = res.result;

endmodule

`default_nettype wire

// File: src/exec_alu.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_consts.svh"

module exec_alu (
        input  wire logic               clk,
        input  wire logic               reset,
        input  wire pipe_pkg::issue_t   issue,
        output pipe_pkg::exec_result_t  res
);

        riscv_isa_pkg::word_t           a;
        riscv_isa_pkg::word_t           b;
        riscv_isa_pkg::word_t           alu_out;
        riscv_isa_pkg::reg_idx_t        shamt;
        logic signed [2*`RV_XLEN-1:0]   prod;
        logic                           div_zero;
        logic                           div_ovf;

        assign a     = issue.op_a;
        assign b     = issue.op_b;
        assign shamt = b[4:0];

        // Full signed product
        assign prod = $signed({{`RV_XLEN{a[`RV_XLEN-1]}}, a}) *
                      $signed({{`RV_XLEN{b[`RV_XLEN-1]}}, b});

        // ******************************
        // Division corner cases
        // ******************************

        assign div_zero = (b == '0);
        assign div_ovf  = (a == {1'b1, {(`RV_XLEN-1){1'b0}}}) && (b == '1);

        always_comb
        begin
                alu_out = '0;

                case (issue.op)
                        riscv_isa_pkg::ADD:   alu_out = a + b;
                        riscv_isa_pkg::SUB:   alu_out = a - b;
                        riscv_isa_pkg::SLL:   alu_out = a << shamt;
                        riscv_isa_pkg::SLT:
                                alu_out = {{(`RV_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
                        riscv_isa_pkg::SLTU:
                                alu_out = {{(`RV_XLEN-1){1'b0}}, (a < b)};
                        riscv_isa_pkg::XOR:   alu_out = a ^ b;
                        riscv_isa_pkg::SRL:   alu_out = a >> shamt;
                        riscv_isa_pkg::SRA:   alu_out = $signed(a) >>> shamt;
                        riscv_isa_pkg::OR:    alu_out = a | b;
                        riscv_isa_pkg::AND:   alu_out = a & b;
                        riscv_isa_pkg::MUL:   alu_out = prod[`RV_XLEN-1:0];
                        riscv_isa_pkg::MULH:  alu_out = prod[2*`RV_XLEN-1:`RV_XLEN];
                        riscv_isa_pkg::DIV:
                        begin
                                if (div_zero)
                                        alu_out = '1;
                                else if (div_ovf)
                                        alu_out = a;
                                else
                                        alu_out = $signed(a) / $signed(b);
                        end
                        riscv_isa_pkg::DIVU:
                        begin
                                if (div_zero)
                                        alu_out = '1;
                                else
                                        alu_out = a / b;
                        end
                        riscv_isa_pkg::REM:
                        begin
                                if (div_zero)
                                        alu_out = a;
                                else if (div_ovf)
                                        alu_out = '0;
                                else
                                        alu_out = $signed(a) % $signed(b); // Sign of dividend
                        end
                        riscv_isa_pkg::REMU:
                        begin
                                if (div_zero)
                                        alu_out = a;
                                else
                                        alu_out = a % b;
                        end
                        riscv_isa_pkg::LUI:   alu_out = b;
                        riscv_isa_pkg::AUIPC: alu_out = a + b;
                        default:              alu_out = a + b;
                endcase
        end

        // Result register
        always_ff @(posedge clk)
        begin
                res.result <= alu_out;

                if (reset)
                        res.valid <= 1'b0;
                else
                        res.valid <= issue.valid;
        end

endmodule

`default_nettype wire

// File: src/id_ex_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_consts.svh"

module id_ex_stage (
        input  wire logic                       clk,
        input  wire logic                       reset,
        input  wire pipe_pkg::decoded_instr_t   dec,
        output pipe_pkg::issue_t                issue
);

        riscv_isa_pkg::word_t sel_a;
        riscv_isa_pkg::word_t sel_b;

        // ******************************
        // Operand select
        // ******************************

        always_comb
        begin
                sel_a = dec.use_pc ? dec.pc : dec.rs1_val;

                if (dec.use_imm)
                        sel_b = dec.imm;
                else if (dec.use_pc)
                        sel_b = riscv_isa_pkg::word_t'(`RV_LINK_OFFSET); // JAL, JALR
                else
                        sel_b = dec.rs2_val;
        end

        // Pipeline register
        always_ff @(posedge clk)
        begin
                issue.op   <= dec.op;
                issue.op_a <= sel_a;
                issue.op_b <= sel_b;

                if (reset)
                        issue.valid <= 1'b0;
                else
                        issue.valid <= dec.valid;
        end

endmodule

`default_nettype wire

// File: src/instr_decode.sv
`default_nettype none
`timescale 1ns/1ps

module instr_decode (
        input  wire logic                   in_valid,
        input  wire riscv_isa_pkg::word_t   instr,
        input  wire riscv_isa_pkg::word_t   rs1_val,
        input  wire riscv_isa_pkg::word_t   rs2_val,
        input  wire riscv_isa_pkg::word_t   pc,
        output pipe_pkg::decoded_instr_t    dec
);

        riscv_isa_pkg::instruction_format_type  opcode;
        riscv_isa_pkg::funct3_t                 funct3;
        riscv_isa_pkg::funct7_t                 funct7;
        riscv_isa_pkg::alu_operation_type       alu_op;
        riscv_isa_pkg::word_t                   imm_i;
        riscv_isa_pkg::word_t                   imm_u;

        assign funct3 = instr[14:12];
        assign funct7 = instr[31:25];

        assign imm_i = {{20{instr[31]}}, instr[31:20]}; // Sign extended
        assign imm_u = {instr[31:12], 12'b0};

        // Unknown opcodes collapse to OTHER
        always_comb
        begin
                case (instr[6:0])
                        riscv_isa_pkg::OP:      opcode = riscv_isa_pkg::OP;
                        riscv_isa_pkg::OP_IMM:  opcode = riscv_isa_pkg::OP_IMM;
                        riscv_isa_pkg::U_LUI:   opcode = riscv_isa_pkg::U_LUI;
                        riscv_isa_pkg::U_AUIPC: opcode = riscv_isa_pkg::U_AUIPC;
                        riscv_isa_pkg::J_JAL:   opcode = riscv_isa_pkg::J_JAL;
                        riscv_isa_pkg::JALR:    opcode = riscv_isa_pkg::JALR;
                        default:                opcode = riscv_isa_pkg::OTHER;
                endcase
        end

        alu_ctrl alu_ctrl_i (
                .funct3 (funct3),
                .funct7 (funct7),
                .opcode (opcode),
                .op     (alu_op)
        );

        always_comb
        begin
                dec.valid   = in_valid;
                dec.op      = alu_op;
                dec.rs1_val = rs1_val;
                dec.rs2_val = rs2_val;
                dec.pc      = pc;

                // pc with no imm selects the link offset downstream
                dec.use_pc  = (opcode == riscv_isa_pkg::U_AUIPC) ||
                              (opcode == riscv_isa_pkg::J_JAL)   ||
                              (opcode == riscv_isa_pkg::JALR);
                dec.use_imm = (opcode == riscv_isa_pkg::OP_IMM) ||
                              (opcode == riscv_isa_pkg::U_LUI)  ||
                              (opcode == riscv_isa_pkg::U_AUIPC);

                if ((opcode == riscv_isa_pkg::U_LUI) || (opcode == riscv_isa_pkg::U_AUIPC))
                        dec.imm = imm_u;
                else
                        dec.imm = imm_i;
        end

endmodule

`default_nettype wire

// File: src/alu_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_consts.svh"

module alu_ctrl (
        input  wire riscv_isa_pkg::funct3_t                 funct3,
        input  wire riscv_isa_pkg::funct7_t                 funct7,
        input  wire riscv_isa_pkg::instruction_format_type  opcode,
        output riscv_isa_pkg::alu_operation_type            op
);

        logic arith; // OP or OP_IMM
        logic reg_op;
        logic m_ext; // Only valid for OP
        logic alt;

        assign reg_op = (opcode == riscv_isa_pkg::OP);
        assign arith  = reg_op || (opcode == riscv_isa_pkg::OP_IMM);
        assign m_ext  = reg_op && (funct7 == `RV_FUNCT7_M);
        assign alt    = (funct7 == `RV_FUNCT7_ALT);

        always_comb
        begin
                op = riscv_isa_pkg::ADD; // Links and everything unsupported

                if (arith)
                begin
                        case (funct3)
                                3'b000:
                                        if (m_ext)
                                                op = riscv_isa_pkg::MUL;
                                        else if (reg_op && alt)
                                                op = riscv_isa_pkg::SUB;
                                        else
                                                op = riscv_isa_pkg::ADD;
                                3'b001:
                                        op = m_ext ? riscv_isa_pkg::MULH : riscv_isa_pkg::SLL;
                                3'b010:
                                        op = riscv_isa_pkg::SLT;
                                3'b011:
                                        op = riscv_isa_pkg::SLTU;
                                3'b100:
                                        op = m_ext ? riscv_isa_pkg::DIV : riscv_isa_pkg::XOR;
                                3'b101:
                                        if (m_ext)
                                                op = riscv_isa_pkg::DIVU;
                                        else if (alt)
                                                op = riscv_isa_pkg::SRA;
                                        else
                                                op = riscv_isa_pkg::SRL;
                                3'b110:
                                        op = m_ext ? riscv_isa_pkg::REM : riscv_isa_pkg::OR;
                                3'b111:
                                        op = m_ext ? riscv_isa_pkg::REMU : riscv_isa_pkg::AND;
                        endcase
                end
                else if (opcode == riscv_isa_pkg::U_LUI)
                begin
                        op = riscv_isa_pkg::LUI;
                end
                else if (opcode == riscv_isa_pkg::U_AUIPC)
                begin
                        op = riscv_isa_pkg::AUIPC;
                end
        end

endmodule

`default_nettype wire

// File: src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

        // ******************************
        // Decode to ID/EX
        // ******************************

        typedef struct packed {
                logic                               valid;
                riscv_isa_pkg::alu_operation_type   op;
                riscv_isa_pkg::word_t               imm;
                logic                               use_imm; // b from imm
                logic                               use_pc;  // a from pc
                riscv_isa_pkg::word_t               rs1_val;
                riscv_isa_pkg::word_t               rs2_val;
                riscv_isa_pkg::word_t               pc;
        } decoded_instr_t;

        // ID/EX to ALU
        typedef struct packed {
                logic                               valid;
                riscv_isa_pkg::alu_operation_type   op;
                riscv_isa_pkg::word_t               op_a;
                riscv_isa_pkg::word_t               op_b;
        } issue_t;

        // ******************************
        // ALU output
        // ******************************

        typedef struct packed {
                logic                   valid;
                riscv_isa_pkg::word_t   result;
        } exec_result_t;

endpackage

`default_nettype wire

// File: src/riscv_isa_pkg.sv
`default_nettype none

`include "rv_consts.svh"

package riscv_isa_pkg;

        // ******************************
        // Field vectors
        // ******************************

        typedef logic [`RV_XLEN-1:0] word_t;
        typedef logic [2:0]          funct3_t;
        typedef logic [6:0]          funct7_t;
        typedef logic [4:0]          reg_idx_t; // Also a bit position within a word

        // ******************************
        // Major opcodes
        // ******************************

        typedef enum logic [6:0] {
                OP      = 7'b011_0011,
                OP_IMM  = 7'b001_0011,
                U_LUI   = 7'b011_0111,
                U_AUIPC = 7'b001_0111,
                J_JAL   = 7'b110_1111,
                JALR    = 7'b110_0111,
                OTHER   = 7'b000_0000 // Loads, stores, branches, system
        } instruction_format_type;

        // ALU operations
        typedef enum logic [4:0] {
                ADD,
                SUB,
                SLL,
                SLT,
                SLTU,
                XOR,
                SRL,
                SRA,
                OR,
                AND,
                MUL,
                MULH,
                DIV,
                DIVU,
                REM,
                REMU,
                LUI,   // Passes operand b
                AUIPC  // pc plus U immediate
        } alu_operation_type;

endpackage

`default_nettype wire

// File: src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data path width
`define RV_XLEN 32

// funct7 codes of the OP format
`define RV_FUNCT7_M   7'b000_0001 // MUL, MULH, DIV, DIVU, REM, REMU
`define RV_FUNCT7_ALT 7'b010_0000 // SUB and SRA, SRAI keeps it in imm[11:5]

// Return address increment for JAL and JALR
`define RV_LINK_OFFSET 4

`endif
